// File: build.f
+incdir+logic
logic/reg_bus_pkg.sv
logic/bus_fsm.sv
logic/fault_fsm.sv
logic/register_error.sv
logic/scratch_registers.sv
logic/reg_bus_top.sv
verification/clock_gen.sv
verification/reg_bus_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = reg_bus_tb
FILELIST = build.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/reg_bus_tb.sv
// register bus testbench

`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module reg_bus_tb;

   // expected outcome of one transfer
   typedef struct packed {
      logic [31:0] word;
      logic        nfault;
      logic [3:0]  latency;
      logic [1:0]  write_strobes;
   } expected_t;

   localparam int illegal_each = 10;
   localparam int fault_steps = 7;
   localparam int hold_count = 8;
   // writes, reads and readback of the bank, illegal reads and writes, fault and hold runs
   localparam int num_transactions = 3 * `SCRATCH_REGS + 2 * illegal_each + fault_steps
                                     + hold_count;
   localparam int timeout_cycles = 200 * num_transactions;

   logic                    clk;
   logic                    reset;
   reg_bus_pkg::host_req_t  req;
   reg_bus_pkg::sub_reply_t reply;
   logic                    nfault;
   logic [31:0]             shadow [`SCRATCH_REGS];
   expected_t               expected;
   logic                    prior_nfault = 1'b1;
   logic                    ack_seen = 1'b0;
   logic [31:0]             held_word;
   int                      request_edges = 0;
   int                      write_strobes = 0;
   int                      cycle_count = 0;

   clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   reg_bus_top u_reg_bus_top (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .reply  (reply),
      .nfault (nfault)
   );

   task automatic compare_value(input string signal_name, input logic [31:0] actual,
                                input logic [31:0] wanted);
      if (actual !== wanted) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, signal_name, actual, wanted);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // reply word, fault line, ack latency and bank writes that the bus rules call for
   function automatic expected_t reference_model(input logic rw, input logic [7:0] addr);
      expected_t result;
      logic      illegal;
      illegal = (addr >= `FIRST_ILLEGAL_REGISTER);
      if (illegal && rw) result.word = {8'(`SUBSYS_ID_ERROR), 1'b1, 15'd0, addr};
      else if (illegal) result.word = `ILLEGAL_READ_WORD;
      else if (rw) result.word = {8'(`SUBSYS_ID_SCRATCH), 1'b0, 15'd0, addr};
      else result.word = shadow[addr[3:0]];
      result.nfault = !illegal;
      result.latency = rw ? 4'd3 : 4'd2;
      result.write_strobes = (rw && !illegal) ? 2'd1 : 2'd0;
      return result;
   endfunction

   function automatic logic [7:0] random_illegal_address();
      return 8'(`FIRST_ILLEGAL_REGISTER +
                ($urandom % (`LAST_REGISTER - `FIRST_ILLEGAL_REGISTER + 1)));
   endfunction

   task automatic wait_ack(input logic level);
      @(negedge clk);
      while (reply.handshake_2 !== level) @(negedge clk);
   endtask

   // one full four-phase transfer
   // hold_cycles keeps the request up after the ack
   task automatic bus_access(input logic rw, input logic [7:0] addr, input logic [31:0] wdata,
                             input int hold_cycles);
      int strobes_before;
      @(posedge clk);
      expected = reference_model(rw, addr);
      strobes_before = write_strobes;
      req.rw <= rw;
      req.reg_address <= addr;
      req.data_out <= wdata;
      req.register_address_valid <= 1'b1;
      @(posedge clk);
      req.handshake_1 <= 1'b1;
      wait_ack(1'b1);
      repeat (hold_cycles + 1) @(posedge clk);
      req.handshake_1 <= 1'b0;
      wait_ack(1'b0);
      compare_value("write strobes", 32'(write_strobes - strobes_before),
                    32'(expected.write_strobes));
      if (rw && addr < `FIRST_ILLEGAL_REGISTER) shadow[addr[3:0]] = wdata;
      prior_nfault = expected.nfault;
   endtask

   // compare on the ack and watch the reply while the host holds the request
   always @(negedge clk) begin
      if (reset && reply.handshake_2 && !ack_seen) begin
         ack_seen = 1'b1;
         held_word = reply.data_in;
         compare_value("data_in", reply.data_in, expected.word);
         compare_value("enable", 32'(reply.enable), 32'd1);
         compare_value("nfault", 32'(nfault), 32'(expected.nfault));
         compare_value("ack latency", 32'(request_edges - 1), 32'(expected.latency));
      end else if (ack_seen && req.handshake_1) begin
         compare_value("handshake_2", 32'(reply.handshake_2), 32'd1);
         compare_value("data_in", reply.data_in, held_word);
         compare_value("nfault", 32'(nfault), 32'(expected.nfault));
      end else if (!reply.handshake_2) begin
         ack_seen = 1'b0;
      end
      // fault line keeps its old level until an illegal access is acknowledged
      if (reset && req.handshake_1 && !reply.handshake_2 && !expected.nfault) begin
         compare_value("nfault", 32'(nfault), 32'(prior_nfault));
      end
      // edges with the request up and no ack yet
      if (!req.handshake_1) request_edges = 0;
      else if (!reply.handshake_2) request_edges++;
   end

   // count bank write pulses
   always @(negedge clk) begin
      if (u_reg_bus_top.u_scratch_registers.read_word) write_strobes++;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
         $display("handshake hung, run passed its limit of %0d cycles", timeout_cycles);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   initial begin
      void'($urandom(32'h744b2150));
      req <= '0;
      for (int i = 0; i < `SCRATCH_REGS; i++) shadow[i] = '0;
      @(posedge reset);
      repeat (2) @(posedge clk);
      @(negedge clk);
      // idle bus out of reset
      compare_value("handshake_2", 32'(reply.handshake_2), 32'd0);
      compare_value("enable", 32'(reply.enable), 32'd0);
      compare_value("nfault", 32'(nfault), 32'd1);
      for (int i = 0; i < `SCRATCH_REGS; i++) bus_access(1'b1, 8'(i), $urandom, 0);
      for (int i = 0; i < `SCRATCH_REGS; i++) begin
         bus_access(1'b0, 8'($urandom % `SCRATCH_REGS), 32'd0, 0);
      end
      for (int i = 0; i < illegal_each; i++) bus_access(1'b0, random_illegal_address(), 0, 0);
      for (int i = 0; i < illegal_each; i++) begin
         bus_access(1'b1, random_illegal_address(), $urandom, 0);
      end
      // bank untouched by the illegal writes
      for (int i = 0; i < `SCRATCH_REGS; i++) bus_access(1'b0, 8'(i), 32'd0, 0);
      // fault set and held over illegal accesses then cleared by legal ones
      bus_access(1'b0, random_illegal_address(), 32'd0, 0);
      bus_access(1'b1, random_illegal_address(), $urandom, 0);
      bus_access(1'b0, random_illegal_address(), 32'd0, 0);
      bus_access(1'b0, 8'($urandom % `SCRATCH_REGS), 32'd0, 0);
      bus_access(1'b1, 8'($urandom % `SCRATCH_REGS), $urandom, 0);
      bus_access(1'b1, random_illegal_address(), $urandom, 0);
      bus_access(1'b0, 8'($urandom % `SCRATCH_REGS), 32'd0, 0);
      // back-pressure on every kind of transfer
      for (int i = 0; i < hold_count; i++) begin
         if (i % 3 == 2) bus_access(1'(i % 2), random_illegal_address(), $urandom,
                                    int'($urandom_range(8, 1)));
         else bus_access(1'(i % 3 == 0), 8'($urandom % `SCRATCH_REGS), $urandom,
                         int'($urandom_range(8, 1)));
      end
      @(posedge clk);
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
   output logic clk,
   output logic reset
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // active low reset held for five clocks
   initial begin
      reset <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b1;
   end

endmodule

`default_nettype wire

// File: logic/reg_bus_top.sv
// register bus top level

`timescale 1ns/1ps
`default_nettype none

module reg_bus_top (
   input  logic                   clk,
   input  logic                   reset,
   input  reg_bus_pkg::host_req_t req,
   output reg_bus_pkg::sub_reply_t reply,
   output logic                   nfault
);

   reg_bus_pkg::sub_reply_t scratch_reply;
   reg_bus_pkg::sub_reply_t error_reply;

   // every subsystem sees the full request and decodes for itself
   scratch_registers u_scratch_registers (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .reply (scratch_reply)
   );

   // only fault source on the bus
   register_error u_register_error (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .reply  (error_reply),
      .nfault (nfault)
   );

   // reply mux, stands in for the shared tri-state lines
   // nobody enabled gives an all-zero reply
   always_comb begin
      if (scratch_reply.enable) begin
         reply = scratch_reply;
      end else if (error_reply.enable) begin
         reply = error_reply;
      end else begin
         reply = '0;
      end
   end

   // address ranges of the subsystems must not overlap
   a_one_hot_enable : assert property (
      @(posedge clk) disable iff (!reset)
      !(scratch_reply.enable && error_reply.enable)
   );

endmodule

`default_nettype wire

// File: logic/scratch_registers.sv
// scratch register bank

`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module scratch_registers (
   input  logic                   clk,
   input  logic                   reset,
   input  reg_bus_pkg::host_req_t req,
   output reg_bus_pkg::sub_reply_t reply
);

   localparam int index_bits = $clog2(`SCRATCH_REGS);

   logic                  enable;
   logic                  handshake_2;
   logic                  read_word;
   logic                  present_data;
   logic                  present_status;
   logic [index_bits-1:0] index;

   logic [`REG_DATA_BITS-1:0] regs [`SCRATCH_REGS];

   reg_bus_pkg::status_t     status_word;
   reg_bus_pkg::reply_word_u reply_word;

   // bank starts at register 0
   assign enable = req.register_address_valid &&
                   (req.reg_address < `SCRATCH_REGS);

   // low address bits pick the register
   assign index = req.reg_address[index_bits-1:0];

   bus_fsm u_bus_fsm (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .handshake_1    (req.handshake_1),
      .rw             (req.rw),
      .handshake_2    (handshake_2),
      .read_word      (read_word),
      .present_data   (present_data),
      .present_status (present_status)
   );

   // bank clears on reset, host expects zeros
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < `SCRATCH_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (read_word) begin
         regs[index] <= req.data_out;
      end
   end

   // ok status, error flag clear
   always_comb begin
      status_word              = '0;
      status_word.subsystem_id = `SUBSYS_ID_BITS'(`SUBSYS_ID_SCRATCH);
      status_word.reg_address  = req.reg_address;
   end

   // reply register, loaded with the ack edge
   always_ff @(posedge clk) begin
      if (present_data) begin
         reply_word.data <= regs[index];
      end else if (present_status) begin
         reply_word.status <= status_word;
      end
   end

   always_comb begin
      reply.handshake_2 = handshake_2;
      reply.enable      = enable;
      reply.data_in     = reply_word;
   end

   // address must still be in the bank a cycle after the request was taken
   a_write_in_bank : assert property (
      @(posedge clk) disable iff (!reset)
      read_word |-> (req.reg_address < `SCRATCH_REGS)
   );

endmodule

`default_nettype wire

// File: logic/register_error.sv
// illegal register subsystem

`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module register_error (
   input  logic                   clk,
   input  logic                   reset,
   input  reg_bus_pkg::host_req_t req,
   output reg_bus_pkg::sub_reply_t reply,
   output logic                   nfault
);

   logic enable;
   logic handshake_2;
   logic present_data;
   logic present_status;
   logic legal_request;
   logic legal_seen;

   reg_bus_pkg::status_t     status_word;
   reg_bus_pkg::reply_word_u reply_word;

   // owns every address above the populated ones
   assign enable = req.register_address_valid &&
                   (req.reg_address >= `FIRST_ILLEGAL_REGISTER) &&
                   (req.reg_address <= `LAST_REGISTER);

   // any request that lands in a real subsystem
   assign legal_request = req.register_address_valid &&
                          (req.reg_address < `FIRST_ILLEGAL_REGISTER);

   // write data goes nowhere, so read_word is left open
   bus_fsm u_bus_fsm (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .handshake_1    (req.handshake_1),
      .rw             (req.rw),
      .handshake_2    (handshake_2),
      .read_word      (),
      .present_data   (present_data),
      .present_status (present_status)
   );

   // one cycle delay, fault clears on the edge after the legal request
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         legal_seen <= 1'b0;
      end else begin
         legal_seen <= legal_request;
      end
   end

   // either load strobe lands on the edge that raises the ack
   fault_fsm u_fault_fsm (
      .clk         (clk),
      .reset       (reset),
      .set_fault   (present_data || present_status),
      .clear_fault (legal_seen),
      .nfault      (nfault)
   );

   // error status, echoes the offending address
   always_comb begin
      status_word              = '0;
      status_word.subsystem_id = `SUBSYS_ID_BITS'(`SUBSYS_ID_ERROR);
      status_word.error        = 1'b1;
      status_word.reg_address  = req.reg_address;
   end

   // reply register
   always_ff @(posedge clk) begin
      if (present_data) begin
         reply_word.data <= `ILLEGAL_READ_WORD;
      end else if (present_status) begin
         reply_word.status <= status_word;
      end
   end

   always_comb begin
      reply.handshake_2 = handshake_2;
      reply.enable      = enable;
      reply.data_in     = reply_word;
   end

endmodule

`default_nettype wire

// File: logic/fault_fsm.sv
// fault line state machine

`timescale 1ns/1ps
`default_nettype none

module fault_fsm (
   input  logic clk,
   input  logic reset,
   // acknowledged illegal access
   input  logic set_fault,
   // request to a legal address seen
   input  logic clear_fault,
   // active low, high means no fault
   output logic nfault
);

   typedef enum logic {
      st_no_fault,
      st_faulted
   } state_t;

   state_t state;
   state_t state_next;

   // next state, set takes priority over clear
   always_comb begin
      state_next = state;
      case (state)
         st_no_fault: begin
            if (set_fault) begin
               state_next = st_faulted;
            end
         end
         st_faulted: begin
            if (clear_fault && !set_fault) begin
               state_next = st_no_fault;
            end
         end
         default: begin
            state_next = st_no_fault;
         end
      endcase
   end

   // line follows the state it is moving into
   // so it changes on the same edge as the event
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state  <= st_no_fault;
         nfault <= 1'b1;
      end else begin
         state  <= state_next;
         nfault <= (state_next == st_no_fault);
      end
   end

endmodule

`default_nettype wire

// File: logic/bus_fsm.sv
// bus handshake state machine

`timescale 1ns/1ps
`default_nettype none

module bus_fsm (
   input  logic clk,
   input  logic reset,
   // this subsystem owns the current address
   input  logic enable,
   input  logic handshake_1,
   input  logic rw,
   output logic handshake_2,
   // take write data off the bus
   output logic read_word,
   // load read data into the reply register
   output logic present_data,
   // load status word into the reply register
   output logic present_status
);

   typedef enum logic [1:0] {
      st_idle,
      st_transfer,
      st_acknowledge,
      st_release
   } state_t;

   state_t state;

   // all outputs are registered
   // strobes default low so each one lasts a single cycle
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state          <= st_idle;
         handshake_2    <= 1'b0;
         read_word      <= 1'b0;
         present_data   <= 1'b0;
         present_status <= 1'b0;
      end else begin
         read_word      <= 1'b0;
         present_data   <= 1'b0;
         present_status <= 1'b0;
         case (state)
            st_idle: begin
               // request seen at edge N
               if (enable && handshake_1) begin
                  state <= st_transfer;
               end
            end
            st_transfer: begin
               // edge N+1, one strobe by direction
               read_word    <= rw;
               present_data <= !rw;
               state        <= st_acknowledge;
            end
            st_acknowledge: begin
               // write path gets one more cycle for the status word
               present_status <= read_word;
               // ack rises with the reply register load
               // N+2 for a read, N+3 for a write
               if (present_data || present_status) begin
                  handshake_2 <= 1'b1;
               end
               // host held handshake_1 high means back-pressure, just wait
               if (handshake_2 && !handshake_1) begin
                  state <= st_release;
               end
            end
            st_release: begin
               // drop ack one cycle after the host let go
               handshake_2 <= 1'b0;
               state       <= st_idle;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // ack only ever goes to the host that addressed this subsystem
   a_ack_needs_enable : assert property (
      @(posedge clk) disable iff (!reset)
      $rose(handshake_2) |-> enable
   );

endmodule

`default_nettype wire

// File: logic/reg_bus_pkg.sv
// register bus types

`default_nettype none

`include "reg_bus_cfg.svh"

package reg_bus_pkg;

   // host request, held stable by the host for the whole handshake
   typedef struct packed {
      logic                         handshake_1;
      // 1 is a write, 0 a read
      logic                         rw;
      logic                         register_address_valid;
      logic [`REG_ADDR_BITS-1:0]    reg_address;
      // write data
      logic [`REG_DATA_BITS-1:0]    data_out;
   } host_req_t;

   // status word returned on a write
   typedef struct packed {
      logic [`SUBSYS_ID_BITS-1:0]   subsystem_id;
      logic                         error;
      // always zero
      logic [14:0]                  reserved;
      logic [`REG_ADDR_BITS-1:0]    reg_address;
   } status_t;

   // one reply word, meaning set by rw of the transfer
   // read gives data, write gives status
   typedef union packed {
      logic [`REG_DATA_BITS-1:0]    data;
      status_t                      status;
   } reply_word_u;

   // reply from one subsystem, enable marks the owner of the address
   typedef struct packed {
      logic                         handshake_2;
      logic                         enable;
      reply_word_u                  data_in;
   } sub_reply_t;

endpackage

`default_nettype wire

// File: logic/reg_bus_cfg.svh
// register bus configuration

`ifndef REG_BUS_CFG_SVH
`define REG_BUS_CFG_SVH

// width of the register number carried on the bus
`define REG_ADDR_BITS 8

// width of one register and of the reply word
`define REG_DATA_BITS 32

// width of the subsystem id field in a status word
`define SUBSYS_ID_BITS 8

// scratch bank sits at the bottom of the map
`define SCRATCH_REGS 16

// everything from here up is unpopulated
`define FIRST_ILLEGAL_REGISTER 16

// highest register number the bus can carry
`define LAST_REGISTER 255

// returned by a read of an unpopulated register
// alternating bits so a stuck data line shows up on the host side
`define ILLEGAL_READ_WORD 32'h55555555

// ids placed in the status word of a write reply
`define SUBSYS_ID_SCRATCH 1
`define SUBSYS_ID_ERROR 2

`endif
